/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eeprom_wr
FILELIST  ?= eeprom_wr.f
LOG       ?= sim.log
TIMEOUT   ?= 60
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)
	{ timeout $(TIMEOUT) ./$(OBJ_DIR)/V$(TOP) || echo "CHECKS FAILED"; } 2>&1 | tee $(LOG)
	@! grep -q "CHECKS FAILED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* byte_shifter.sv */
`timescale 1ns/1ps
module byte_shifter import eeprom_pkg::*;
(
    input  logic          CLK,
    input  logic          RESET,
    input  logic          low_mid,
    input  logic          high_mid,
    output logic          run,
    eeprom_bus_if.shifter bus,
    output logic          sda_oe,
    input  logic          sda_in
);

    ee_cond_t   cur_op;
    logic       phase;    // start/stop set up, or tx/rx in the ack bit
    logic [3:0] bit_cnt;
    ee_byte_t   shreg;    // out on tx, in on rx
    logic       last_q;

    // done is combinational so the next go lands before the next low_mid
    assign bus.done     = high_mid && phase;
    assign bus.rx_byte  = shreg;
    assign bus.dev_nack = (cur_op == OP_TX) && sda_in;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cur_op  <= OP_NONE;
            phase   <= 1'b0;
            bit_cnt <= '0;
            run     <= 1'b0;
            sda_oe  <= 1'b0;
        end
        else if (high_mid && phase)
        begin
            phase  <= 1'b0;
            cur_op <= OP_NONE;
            if (cur_op == OP_START)
                sda_oe <= 1'b1;  // sda falls with scl high
            if (cur_op == OP_STOP)
            begin
                sda_oe <= 1'b0;  // sda rises with scl high
                run    <= 1'b0;
            end
        end
        else if (cur_op == OP_NONE)
        begin
            if (bus.go)
            begin
                cur_op  <= bus.op;
                bit_cnt <= '0;
                shreg   <= bus.tx_byte;
                last_q  <= bus.tx_last;
                if (bus.op == OP_START)
                begin
                    run   <= 1'b1;
                    phase <= !run;  // idle bus, sda already high
                end
            end
        end
        else
        begin
            case (cur_op)
                OP_START,
                OP_STOP:
                    if (low_mid)
                    begin
                        sda_oe <= (cur_op == OP_STOP);
                        phase  <= 1'b1;
                    end
                OP_TX:
                    if (low_mid)
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            sda_oe <= 1'b0;  // device drives ack
                            phase  <= 1'b1;
                        end
                        else
                        begin
                            sda_oe  <= !shreg[7];  // msb first
                            shreg   <= {shreg[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                OP_RX:
                    if (low_mid)
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            sda_oe <= !last_q;
                            phase  <= 1'b1;
                        end
                        else
                            sda_oe <= 1'b0;
                    end
                    else if (high_mid && bit_cnt != 4'd8)
                    begin
                        shreg   <= {shreg[6:0], sda_in};
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                default:
                    cur_op <= OP_NONE;
            endcase
        end
    end

    // outside start/stop, sda moves only in the low half of scl
    a_sda_on_low: assert property (
        @(posedge CLK) disable iff (RESET)
        $changed(sda_oe) |-> $past(low_mid) || $past(cur_op inside {OP_START, OP_STOP})
    );

endmodule

/* eeprom_bus_if.sv */
`timescale 1ns/1ps
interface eeprom_bus_if import eeprom_pkg::*; ();

    ee_cond_t op;
    logic     go;        // one cycle, op valid with it
    ee_byte_t tx_byte;
    logic     tx_last;   // nack after the received byte

    logic     done;      // one cycle, end of op
    ee_byte_t rx_byte;
    logic     dev_nack;  // valid with done

    modport fsm (
        output op,
        output go,
        output tx_byte,
        output tx_last,
        input  done,
        input  rx_byte,
        input  dev_nack
    );

    modport shifter (
        input  op,
        input  go,
        input  tx_byte,
        input  tx_last,
        output done,
        output rx_byte,
        output dev_nack
    );

endinterface

/* eeprom_ctrl_fsm.sv */
`timescale 1ns/1ps
module eeprom_ctrl_fsm import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      wr,
    input  logic      rd,
    input  ee_addr_t  addr,
    input  ee_byte_t  wdata,
    output ee_byte_t  rdata,
    output logic      ack,
    output logic      nack,
    output logic      busy,
    eeprom_bus_if.fsm bus
);

    ee_state_t state;
    logic      is_rd;
    ee_addr_t  addr_q;
    ee_byte_t  wdata_q;
    logic      op_pending;  // go issued, done not yet seen

    // device code, block select a[10:8], r/w
    function automatic ee_byte_t ctrl_byte(input ee_addr_t a, input logic rw);
        return {DEV_CODE, a[10:8], rw};
    endfunction

    assign busy = (state != IDLE) && (state != DONE);
    assign ack  = (state == DONE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= IDLE;
            is_rd       <= 1'b0;
            nack        <= 1'b0;
            bus.go      <= 1'b0;
            bus.op      <= OP_NONE;
            bus.tx_last <= 1'b0;
        end
        else
        begin
            bus.go <= 1'b0;
            if (!busy && (wr || rd))
            begin
                is_rd   <= !wr;  // wr wins
                addr_q  <= addr;
                wdata_q <= wdata;
                nack    <= 1'b0;
                state   <= START;
                bus.go  <= 1'b1;
                bus.op  <= OP_START;
            end
            else if (state == DONE)
                state <= IDLE;
            else if (bus.done)
            begin
                nack        <= nack | bus.dev_nack;  // any byte missed
                bus.tx_last <= 1'b0;
                bus.go      <= (state != STOP);
                case (state)
                    START:
                    begin
                        state       <= CTRL_WR;
                        bus.op      <= OP_TX;
                        bus.tx_byte <= ctrl_byte(addr_q, 1'b0);
                    end
                    CTRL_WR:
                    begin
                        state       <= ADDR_LO;
                        bus.op      <= OP_TX;
                        bus.tx_byte <= addr_q[7:0];
                    end
                    ADDR_LO:
                        if (is_rd)
                        begin
                            state  <= RESTART;
                            bus.op <= OP_START;
                        end
                        else
                        begin
                            state       <= DATA_WR;
                            bus.op      <= OP_TX;
                            bus.tx_byte <= wdata_q;
                        end
                    DATA_WR:
                    begin
                        state  <= STOP;
                        bus.op <= OP_STOP;
                    end
                    RESTART:
                    begin
                        state       <= CTRL_RD;
                        bus.op      <= OP_TX;
                        bus.tx_byte <= ctrl_byte(addr_q, 1'b1);
                    end
                    CTRL_RD:
                    begin
                        state       <= DATA_RD;
                        bus.op      <= OP_RX;
                        bus.tx_last <= 1'b1;  // single byte, nack it
                    end
                    DATA_RD:
                    begin
                        rdata  <= bus.rx_byte;
                        state  <= STOP;
                        bus.op <= OP_STOP;
                    end
                    STOP:
                        state <= DONE;
                    default:
                        state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            op_pending <= 1'b0;
        else if (bus.go)
            op_pending <= 1'b1;
        else if (bus.done)
            op_pending <= 1'b0;
    end

    // transaction ends only once the stop is done
    a_ack_shifter_idle: assert property (
        @(posedge CLK) disable iff (RESET)
        ack |-> !op_pending
    );

    a_go_after_done: assert property (
        @(posedge CLK) disable iff (RESET)
        bus.go |-> !op_pending
    );

endmodule

/* eeprom_model.sv */
`timescale 1ns/1ps
module eeprom_model import eeprom_pkg::*;
(
    input  logic scl,
    inout  wire  sda,
    input  logic ack_en
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_READ
    } model_mode_t;

    ee_byte_t    mem [0:2047];
    model_mode_t mode;
    logic [3:0]  cnt;        // 0..7 data bits, 8 is the ack slot
    logic        fresh;      // first scl fall after a start
    logic        drive_low;
    ee_byte_t    shreg;
    ee_byte_t    rd_byte;
    ee_byte_t    ptr_lo;
    logic [2:0]  blk;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;  // erased part
        mode      = M_IDLE;
        cnt       = '0;
        fresh     = 1'b0;
        drive_low = 1'b0;
        blk       = '0;
        ptr_lo    = '0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode      = M_CTRL;
            cnt       = '0;
            fresh     = 1'b1;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode      = M_IDLE;  // stop
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (mode == M_READ)
        begin
            if (cnt == 4'd8 && sda !== 1'b0)
                mode = M_IDLE;  // master nack ends the read
        end
        else if (mode != M_IDLE && cnt < 4'd8)
            shreg = {shreg[6:0], (sda !== 1'b0)};
    end

    always @(negedge scl)
    begin
        if (fresh)
            fresh = 1'b0;
        else
        begin
            cnt = (cnt == 4'd8) ? 4'd0 : cnt + 1'b1;
            if (cnt == 4'd8)
            begin
                case (mode)
                    M_CTRL:
                        if (shreg[7:4] == DEV_CODE && ack_en)
                        begin
                            blk       = shreg[3:1];
                            drive_low = 1'b1;
                            if (shreg[0])
                            begin
                                mode    = M_READ;
                                rd_byte = mem[{blk, ptr_lo}];
                            end
                            else
                                mode = M_ADDR;
                        end
                        else
                            mode = M_IDLE;
                    M_ADDR:
                    begin
                        ptr_lo    = shreg;
                        mode      = M_WDATA;
                        drive_low = 1'b1;
                    end
                    M_WDATA:
                    begin
                        mem[{blk, ptr_lo}] = shreg;
                        mode      = M_IDLE;
                        drive_low = 1'b1;
                    end
                    default:
                        drive_low = 1'b0;  // master owns the ack slot on reads
                endcase
            end
            else
            begin
                drive_low = 1'b0;
                if (mode == M_READ)
                    drive_low = !rd_byte[7 - cnt];
            end
        end
    end

endmodule

/* eeprom_pkg.sv */
package eeprom_pkg;

    // 24C16 style part, 2048 bytes
    typedef logic [10:0] ee_addr_t;

    typedef logic [7:0] ee_byte_t;

    // upper nibble of the control byte
    typedef logic [3:0] ee_dev_code_t;

    localparam ee_dev_code_t DEV_CODE = 4'b1010;

    // transaction sequencing
    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR_LO,
        DATA_WR,
        RESTART,   // reads only
        CTRL_RD,
        DATA_RD,
        STOP,
        DONE       // ack cycle
    } ee_state_t;

    // one operation of the byte shifter
    typedef enum logic [2:0] {
        OP_NONE,
        OP_START,  // also used for the repeated start
        OP_STOP,
        OP_TX,     // byte out, device ack in
        OP_RX      // byte in, master ack/nack out
    } ee_cond_t;

endpackage

/* eeprom_wr.f */
eeprom_pkg.sv
eeprom_bus_if.sv
scl_timer.sv
byte_shifter.sv
eeprom_ctrl_fsm.sv
eeprom_wr.sv
eeprom_model.sv
tb_clock.sv
tb_eeprom_wr.sv

/* eeprom_wr.sv */
`timescale 1ns/1ps
module eeprom_wr import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 2  // CLK cycles per half scl period
) (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     wr,
    input  logic     rd,
    input  ee_addr_t addr,
    input  ee_byte_t wdata,
    output ee_byte_t rdata,
    output logic     ack,
    output logic     nack,
    output logic     busy,
    output logic     scl,
    inout  wire      sda
);

    logic run;
    logic low_mid;
    logic high_mid;
    logic sda_oe;

    eeprom_bus_if bus ();

    // open drain, pulled up outside
    assign sda = sda_oe ? 1'b0 : 1'bz;

    scl_timer #(
        .CLK_DIV(CLK_DIV)
    ) i_scl_timer (
        .CLK(CLK),
        .RESET(RESET),
        .run(run),
        .scl(scl),
        .low_mid(low_mid),
        .high_mid(high_mid)
    );

    byte_shifter i_byte_shifter (
        .CLK(CLK),
        .RESET(RESET),
        .low_mid(low_mid),
        .high_mid(high_mid),
        .run(run),
        .bus(bus.shifter),
        .sda_oe(sda_oe),
        .sda_in(sda)
    );

    eeprom_ctrl_fsm i_ctrl_fsm (
        .CLK(CLK),
        .RESET(RESET),
        .wr(wr),
        .rd(rd),
        .addr(addr),
        .wdata(wdata),
        .rdata(rdata),
        .ack(ack),
        .nack(nack),
        .busy(busy),
        .bus(bus.fsm)
    );

endmodule

/* scl_timer.sv */
`timescale 1ns/1ps
module scl_timer #(
    parameter int CLK_DIV = 2
) (
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic scl,
    output logic low_mid,
    output logic high_mid
);

    localparam int CW  = $clog2(CLK_DIV);
    localparam int MID = CLK_DIV / 2;

    logic [CW-1:0] cnt;  // cycles left in the current half period

    always_ff @(posedge CLK)
    begin
        if (RESET || !run)
        begin
            scl <= 1'b1;  // park high, first half period after run is high
            cnt <= CW'(CLK_DIV - 1);
        end
        else if (cnt == '0)
        begin
            scl <= !scl;
            cnt <= CW'(CLK_DIV - 1);
        end
        else
        begin
            cnt <= cnt - 1'b1;
        end
    end

    // strobes sit away from both scl edges, sda gets a cycle of margin
    assign low_mid  = run && !scl && (cnt == CW'(MID));
    assign high_mid = run && scl && (cnt == CW'(MID));

    // high_mid half an scl period after each low_mid
    a_strobes_apart: assert property (
        @(posedge CLK) disable iff (RESET)
        $past(low_mid, CLK_DIV) && run |-> high_mid
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps
module tb_clock (
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK   = 1'b0;
        RESET = 1'b1;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
    end

    always #4 CLK = !CLK;  // 8 ns period

endmodule

/* tb_eeprom_wr.sv */
`timescale 1ns/1ps
module tb_eeprom_wr import eeprom_pkg::*;
();

    localparam int CLK_DIV = 2;
    localparam int N_ROWS  = 29;
    localparam int LIMIT   = N_ROWS * 40 * 2 * CLK_DIV + 10;

    logic     CLK;
    logic     RESET;
    logic     wr;
    logic     rd;
    logic     ack;
    logic     nack;
    logic     busy;
    logic     scl;
    logic     ack_en;
    ee_addr_t addr;
    ee_byte_t wdata;
    ee_byte_t rdata;
    wire      sda;

    logic     row_wr [N_ROWS];
    ee_addr_t row_addr [N_ROWS];
    ee_byte_t row_wdata [N_ROWS];
    logic     row_ack_en [N_ROWS];
    ee_byte_t row_exp_data [N_ROWS];
    logic     row_exp_nack [N_ROWS];
    ee_byte_t shadow [0:2047];

    int          n_rows = 0;
    int          errors = 0;
    int          accepted = 0;
    int          ack_cnt = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'he4d8ec6a;

    pullup (sda);

    tb_clock i_tb_clock (.CLK(CLK), .RESET(RESET));

    eeprom_wr #(.CLK_DIV(CLK_DIV)) i_eeprom_wr (
        .CLK(CLK),
        .RESET(RESET),
        .wr(wr),
        .rd(rd),
        .addr(addr),
        .wdata(wdata),
        .rdata(rdata),
        .ack(ack),
        .nack(nack),
        .busy(busy),
        .scl(scl),
        .sda(sda)
    );

    eeprom_model i_eeprom_model (.scl(scl), .sda(sda), .ack_en(ack_en));

    // galois form, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic add_row(input logic w, input ee_addr_t a, input ee_byte_t d, input logic en);
        row_wr[n_rows]     = w;
        row_addr[n_rows]   = a;
        row_wdata[n_rows]  = d;
        row_ack_en[n_rows] = en;
        n_rows++;
    endtask

    task automatic check_byte(input string name, input ee_byte_t got, input ee_byte_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERROR t=%0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic apply_row(input int i);
        int n;
        int err0;
        err0 = errors;
        n = 0;
        @(negedge CLK);
        ack_en = row_ack_en[i];
        addr   = row_addr[i];
        wdata  = row_wdata[i];
        wr     = row_wr[i];
        rd     = !row_wr[i];
        accepted++;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        while (ack !== 1'b1)
        begin
            @(negedge CLK);
            n++;
            if (i == 0 && n == 5)
            begin
                check_flag("busy", busy, 1'b1);
                wr    = 1'b1;  // must be ignored
                addr  = 11'h050;
                wdata = 8'h3c;
            end
            else if (i == 0 && n == 6)
                wr = 1'b0;
        end
        check_flag("busy", busy, 1'b0);  // falls with ack
        if (!row_wr[i])
            check_byte("rdata", rdata, row_exp_data[i]);
        check_flag("nack", nack, row_exp_nack[i]);
        $display("row %0d %s addr=%03h data=%02h ack_en=%b %s", i, row_wr[i] ? "wr" : "rd",
                 row_addr[i], row_wr[i] ? row_wdata[i] : rdata, row_ack_en[i],
                 (errors == err0) ? "ok" : "fail");
    endtask

    always @(negedge CLK)
        if (ack === 1'b1)
            ack_cnt++;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles > LIMIT)
        begin
            $display("timeout after %0d cycles, no ack from the DUT", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial
    begin
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        ack_en = 1'b1;
        for (int k = 0; k < 2048; k++)
            shadow[k] = 8'hff;
        add_row(1, 11'h123, 8'ha5, 1);
        add_row(0, 11'h123, 8'h00, 1);
        add_row(1, 11'h023, 8'h5a, 1);  // upper bits only differ
        add_row(1, 11'h723, 8'hc3, 1);
        add_row(0, 11'h123, 8'h00, 1);
        add_row(0, 11'h023, 8'h00, 1);
        add_row(0, 11'h723, 8'h00, 1);
        add_row(0, 11'h050, 8'h00, 1);  // never written
        add_row(1, 11'h200, 8'h77, 0);  // no device
        add_row(0, 11'h200, 8'h00, 0);
        add_row(0, 11'h200, 8'h00, 1);
        add_row(1, 11'h200, 8'h88, 1);
        add_row(0, 11'h200, 8'h00, 1);
        for (int k = 0; k < 8; k++)
        begin
            ee_addr_t a;
            ee_byte_t d;
            a = ee_addr_t'(rand_bits(11));
            d = ee_byte_t'(rand_bits(8));
            add_row(1, a, d, 1);
            add_row(0, a, 8'h00, 1);
        end
        // expected values from the shadow memory
        for (int i = 0; i < n_rows; i++)
        begin
            row_exp_nack[i] = !row_ack_en[i];
            row_exp_data[i] = row_ack_en[i] ? shadow[row_addr[i]] : 8'hff;
            if (row_wr[i] && row_ack_en[i])
                shadow[row_addr[i]] = row_wdata[i];
        end

        @(negedge CLK);
        while (RESET)
            @(negedge CLK);
        check_flag("ack", ack, 1'b0);
        check_flag("nack", nack, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("scl", scl, 1'b1);
        check_flag("sda", sda, 1'b1);

        for (int i = 0; i < n_rows; i++)
            apply_row(i);

        repeat (4) @(negedge CLK);
        if (ack_cnt != accepted)
        begin
            errors++;
            $display("saw %0d ack pulses for %0d accepted strobes", ack_cnt, accepted);
        end
        $display("rows=%0d errors=%0d", n_rows, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
